//--- flist.f
avtx_pkg.sv
avtx_beat_counter.sv
avtx_fifo.sv
avtx_addr_table.sv
avtx_avl_slave.sv
avtx_tlp_fsm.sv
avtx_top.sv
tb_avtx_top.sv

//--- run.sh
#!/bin/sh
# Compile the bridge testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_avtx_top -Mdir obj_dir -f flist.f
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/Vtb_avtx_top > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q -F '*** PASSED ***' sim.log; then
  exit 0
fi
exit 1

//--- tb_avtx_top.sv
/*
  Testbench for the Avalon to PCIe memory write bridge.
  Programs the translation table over APB, writes random Avalon bursts
  and checks every streamed TLP beat against a queue model, with
  assertions on stream stability and on burst wait-request.
*/
`timescale 1ns/100ps

module tb_avtx_top;

  localparam int AVL_ADDR_W  = 14;
  localparam int PASS_BITS   = 16;
  localparam int CMD_DEPTH   = 8;
  localparam int DATA_DEPTH  = 64;
  localparam int MAX_BURST   = 16;
  localparam int BYTE_W      = AVL_ADDR_W + 4;
  localparam int N_ENTRIES   = 1 << (BYTE_W - PASS_BITS);
  localparam int WAIT_LIMIT  = 400;          // Cycles before a wait gives up
  localparam logic [7:0]  MWR32 = 8'h40;
  localparam logic [31:0] SEED  = 32'h4813_04ef;

  logic                 clk;
  logic                 rstn;
  avtx_pkg::avl_wr_t    avl_wr;
  logic                 wait_req;
  avtx_pkg::apb_req_t   apb_req;
  avtx_pkg::apb_rsp_t   apb_rsp;
  logic [15:0]          req_id;
  avtx_pkg::tx_st_t     tx_st;
  logic                 tx_ready;
  logic [130:0]         tx_bits;

  logic [129:0] exp_q [$];                   // {sop, eop, beat}
  logic [129:0] exp_beat;
  logic [31:0]  tbl [N_ENTRIES];             // Table contents as read back
  logic [31:0]  rnd_state;
  logic [31:0]  rdy_state;
  logic [31:0]  rdata;
  logic [31:0]  r;
  logic         err;
  logic         ready_random;
  logic         ready_level;
  logic         mid_burst;
  int           errors;
  int           err_mark;
  int           n_checks;
  int           accepted;
  int           expect_n;
  int           i;

  avtx_top #(
    .AVL_ADDR_W (AVL_ADDR_W),
    .PASS_BITS  (PASS_BITS),
    .CMD_DEPTH  (CMD_DEPTH),
    .DATA_DEPTH (DATA_DEPTH),
    .MAX_BURST  (MAX_BURST)
  ) i_dut (
    .Clk_i           (clk),
    .Rstn_i          (rstn),
    .avl_wr_i        (avl_wr),
    .TxWaitRequest_o (wait_req),
    .apb_req_i       (apb_req),
    .apb_rsp_o       (apb_rsp),
    .requester_id_i  (req_id),
    .tx_st_o         (tx_st),
    .TxStReady_i     (tx_ready)
  );

  assign tx_bits = tx_st;

  always #4 clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rnd_state = xorshift(rnd_state);
    return rnd_state;
  endfunction

  // Link ready, either a level or a random pattern
  always @(negedge clk)
  begin
    if (ready_random)
    begin
      rdy_state = xorshift(rdy_state);
      tx_ready  = rdy_state[7];
    end
    else
      tx_ready = ready_level;
  end

  // Whole beat holds while the link stalls it
  a_hold: assert property (@(posedge clk) disable iff (!rstn)
    (tx_st.valid && !tx_ready) |=> $stable(tx_bits))
    else begin errors++; $display("FAIL %0t: stream beat changed while stalled", $time); end

  a_sop: assert property (@(posedge clk) disable iff (!rstn)
    tx_st.sop |-> (tx_st.valid && !tx_st.eop))
    else begin errors++; $display("FAIL %0t: sop without valid or with eop", $time); end

  a_eop: assert property (@(posedge clk) disable iff (!rstn)
    tx_st.eop |-> tx_st.valid)
    else begin errors++; $display("FAIL %0t: eop without valid", $time); end

  a_no_stall: assert property (@(posedge clk) disable iff (!rstn)
    mid_burst |-> !wait_req)
    else begin errors++; $display("FAIL %0t: burst stalled after first beat", $time); end

  // Compare every moved beat with the head of the model
  always @(posedge clk)
  begin
    if (rstn && tx_st.valid && tx_ready)
    begin
      n_checks++;
      if (exp_q.size() == 0)
      begin
        errors++;
        $display("Error at %0t: a stream beat was sent when none was expected", $time);
      end
      else
      begin
        exp_beat = exp_q.pop_front();
        a_beat: assert ({tx_st.sop, tx_st.eop, tx_st.data} == exp_beat)
          else begin
            errors++;
            $display("FAIL %0t: beat %h, expected %h", $time,
                     {tx_st.sop, tx_st.eop, tx_st.data}, exp_beat);
          end
      end
    end
  end

  task automatic check_true(input logic ok, input string msg);
    assert (ok) else begin errors++; $display("FAIL %0t: %s", $time, msg); end
  endtask

  task automatic stop_on_timeout(input string what);
    $display("Timeout at %0t: %s did not happen in time", $time, what);
    $display("*** FAILED ***");
    $finish;
  endtask

  task automatic report_test(input int num, input string name);
    $display("Test %0d (%s) finished with %0d errors", num, name, errors - err_mark);
    err_mark = errors;
  endtask

  // One APB transfer, sampled in the middle of the access phase
  task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rd, output logic slverr);
    int cnt;
    cnt = 0;
    @(negedge clk);
    apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
    @(negedge clk);
    apb_req.penable = 1'b1;
    #2;
    while (!apb_rsp.pready)
    begin
      cnt++;
      if (cnt > WAIT_LIMIT)
        stop_on_timeout("APB pready");
      @(negedge clk);
      #2;
    end
    rd     = apb_rsp.prdata;
    slverr = apb_rsp.pslverr;
    @(negedge clk);
    apb_req = '0;
  endtask

  // Writes one burst and adds its TLP to the model
  task automatic send_burst(input int entry, input int n);
    logic [127:0]        words [MAX_BURST];
    logic [BYTE_W-1:0]   byte_addr;
    logic [31:0]         pcie;
    logic [31:0]         x;
    logic                taken;
    int                  beat;
    int                  cnt;
    x = next_rand();
    byte_addr = {x[BYTE_W-5:0], 4'h0};
    byte_addr[BYTE_W-1:PASS_BITS] = (BYTE_W-PASS_BITS)'(entry);
    pcie = {tbl[entry][31:PASS_BITS], byte_addr[PASS_BITS-1:0]};
    exp_q.push_back({1'b1, 1'b0, 32'h0, pcie & 32'hffff_fffc, req_id, 8'h00, 4'hF, 4'hF,
                     MWR32, 14'h0, 10'(n * 4)});
    for (beat = 0; beat < n; beat++)
    begin
      for (int k = 0; k < 4; k++)
        words[beat][32*k +: 32] = next_rand();
      exp_q.push_back({1'b0, beat == n - 1, words[beat]});
    end
    @(negedge clk);
    avl_wr = '0;
    avl_wr.write      = 1'b1;
    avl_wr.address[AVL_ADDR_W-1:0] = byte_addr[BYTE_W-1:4];
    avl_wr.burstcount = avtx_pkg::BURST_W'(n);
    avl_wr.writedata  = words[0];
    beat = 0;
    cnt  = 0;
    while (beat < n)
    begin
      taken = !wait_req;                     // Stable until the next rising edge
      @(posedge clk);
      @(negedge clk);
      if (taken)
      begin
        beat++;
        mid_burst = (beat < n);
        if (beat < n)
          avl_wr.writedata = words[beat];
      end
      else
      begin
        cnt++;
        if (cnt > WAIT_LIMIT)
          stop_on_timeout("Avalon wait-request release");
      end
    end
    avl_wr    = '0;
    mid_burst = 1'b0;
  endtask

  task automatic wait_drain(input string what);
    int cnt;
    cnt = 0;
    while (exp_q.size() != 0)
    begin
      @(negedge clk);
      cnt++;
      if (cnt > WAIT_LIMIT)
        stop_on_timeout(what);
    end
    repeat (4) @(negedge clk);
  endtask

  initial
  begin
    clk = 1'b0;
    rstn = 1'b0;
    avl_wr = '0;
    apb_req = '0;
    tx_ready = 1'b0;
    ready_random = 1'b0;
    ready_level = 1'b1;
    mid_burst = 1'b0;
    errors = 0;
    err_mark = 0;
    n_checks = 0;
    rnd_state = SEED;
    rdy_state = SEED ^ 32'h5a5a_a5a5;
    r = next_rand();
    req_id = r[15:0];
    repeat (3) @(posedge clk);
    @(negedge clk);
    rstn = 1'b1;

    check_true(!tx_st.valid && !wait_req && !apb_rsp.pslverr, "outputs not idle after reset");
    for (i = 0; i < N_ENTRIES; i++)
    begin
      apb_access(1'b0, 8'(i * 4), 32'h0, rdata, err);
      check_true(rdata == 32'h0 && !err, $sformatf("entry %0d not zero after reset", i));
    end
    for (i = 0; i < N_ENTRIES; i++)
    begin
      r = next_rand();
      apb_access(1'b1, 8'(i * 4), r, rdata, err);
      tbl[i] = {r[31:PASS_BITS], {PASS_BITS{1'b0}}};   // Page bits kept only
    end
    apb_access(1'b1, 8'(N_ENTRIES * 4), next_rand(), rdata, err);
    check_true(err, "no pslverr on write past the table");
    apb_access(1'b0, 8'(N_ENTRIES * 4), 32'h0, rdata, err);
    check_true(err && rdata == 32'h0, "bad response on read past the table");
    for (i = 0; i < N_ENTRIES; i++)
    begin
      apb_access(1'b0, 8'(i * 4), 32'h0, rdata, err);
      check_true(rdata == tbl[i] && !err, $sformatf("entry %0d read %h", i, rdata));
    end
    report_test(1, "reset and table");

    r = next_rand();
    send_burst(int'(r % N_ENTRIES), 1);
    wait_drain("single word TLP");
    report_test(2, "single word");

    for (i = 0; i < 20; i++)
    begin
      r = next_rand();
      send_burst(int'(r[31:16] % N_ENTRIES), 1 + int'(r[15:0] % MAX_BURST));
    end
    wait_drain("random burst TLPs");
    report_test(3, "random bursts");

    ready_random = 1'b1;
    for (i = 0; i < 20; i++)
    begin
      r = next_rand();
      send_burst(int'(r[31:16] % N_ENTRIES), 1 + int'(r[15:0] % MAX_BURST));
    end
    wait_drain("TLPs under random ready");
    ready_random = 1'b0;
    report_test(4, "random back-pressure");

    // Bursts that fit before the data FIFO runs short
    expect_n = 0;
    while ((DATA_DEPTH - expect_n * MAX_BURST) >= MAX_BURST && expect_n < CMD_DEPTH)
      expect_n++;
    ready_level = 1'b0;
    accepted = 0;
    @(negedge clk);
    while (!wait_req && accepted <= CMD_DEPTH)
    begin
      r = next_rand();
      send_burst(int'(r % N_ENTRIES), MAX_BURST);
      accepted++;
    end
    check_true(accepted == expect_n,
               $sformatf("%0d bursts accepted, expected %0d", accepted, expect_n));
    repeat (3) @(negedge clk);
    check_true(wait_req, "wait-request dropped while the link is stalled");
    ready_level = 1'b1;
    wait_drain("TLPs after stall release");
    report_test(5, "full FIFO stall");

    $display("Summary: %0d beats checked, %0d errors", n_checks, errors);
    if (errors == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule

//--- avtx_top.sv
/*
  Avalon to PCIe transmit bridge for memory writes.
  Fixes the bridge parameters and connects the Avalon slave, the
  translation table, the command and data FIFOs and the TLP transmitter.
*/
`timescale 1ns/100ps

module avtx_top #(
  parameter int AVL_ADDR_W = 14,
  parameter int PASS_BITS  = 16,
  parameter int CMD_DEPTH  = 8,
  parameter int DATA_DEPTH = 64,
  parameter int MAX_BURST  = 16
) (
  input  logic                  Clk_i,
  input  logic                  Rstn_i,
  input  avtx_pkg::avl_wr_t     avl_wr_i,
  output logic                  TxWaitRequest_o,
  input  avtx_pkg::apb_req_t    apb_req_i,
  output avtx_pkg::apb_rsp_t    apb_rsp_o,
  input  logic [15:0]           requester_id_i,
  output avtx_pkg::tx_st_t      tx_st_o,
  input  logic                  TxStReady_i
);

  logic [AVL_ADDR_W+3:0]            lookup_addr;
  logic [31:0]                      pcie_addr;
  logic                             data_push;
  logic [avtx_pkg::DATA_W-1:0]      data_in;
  logic [avtx_pkg::DATA_W-1:0]      data_head;
  logic                             data_pop;
  logic [$clog2(DATA_DEPTH):0]      data_free;
  logic                             cmd_push;
  avtx_pkg::tlp_cmd_t               cmd_in;
  avtx_pkg::tlp_cmd_t               cmd_head;
  logic                             cmd_pop;
  logic                             cmd_empty;
  logic [$clog2(CMD_DEPTH):0]       cmd_free;

  avtx_avl_slave #(
    .AVL_ADDR_W (AVL_ADDR_W),
    .CMD_DEPTH  (CMD_DEPTH),
    .DATA_DEPTH (DATA_DEPTH),
    .MAX_BURST  (MAX_BURST)
  ) i_avl_slave (
    .Clk_i           (Clk_i),
    .Rstn_i          (Rstn_i),
    .avl_wr_i        (avl_wr_i),
    .TxWaitRequest_o (TxWaitRequest_o),
    .lookup_addr_o   (lookup_addr),
    .pcie_addr_i     (pcie_addr),
    .data_push_o     (data_push),
    .data_o          (data_in),
    .cmd_push_o      (cmd_push),
    .cmd_o           (cmd_in),
    .cmd_free_i      (cmd_free),
    .data_free_i     (data_free)
  );

  avtx_addr_table #(
    .AVL_ADDR_W (AVL_ADDR_W),
    .PASS_BITS  (PASS_BITS)
  ) i_addr_table (
    .Clk_i         (Clk_i),
    .Rstn_i        (Rstn_i),
    .apb_req_i     (apb_req_i),
    .apb_rsp_o     (apb_rsp_o),
    .lookup_addr_i (lookup_addr),
    .pcie_addr_o   (pcie_addr)
  );

  avtx_fifo #(
    .WIDTH ($bits(avtx_pkg::tlp_cmd_t)),
    .DEPTH (CMD_DEPTH)
  ) i_cmd_fifo (
    .Clk_i   (Clk_i),
    .Rstn_i  (Rstn_i),
    .push_i  (cmd_push),
    .din_i   (cmd_in),
    .pop_i   (cmd_pop),
    .dout_o  (cmd_head),
    .empty_o (cmd_empty),
    .free_o  (cmd_free)
  );

  // Data FIFO needs no empty flag, payload is always ahead of its command
  avtx_fifo #(
    .WIDTH (avtx_pkg::DATA_W),
    .DEPTH (DATA_DEPTH)
  ) i_data_fifo (
    .Clk_i   (Clk_i),
    .Rstn_i  (Rstn_i),
    .push_i  (data_push),
    .din_i   (data_in),
    .pop_i   (data_pop),
    .dout_o  (data_head),
    .empty_o (),
    .free_o  (data_free)
  );

  avtx_tlp_fsm i_tlp_fsm (
    .Clk_i          (Clk_i),
    .Rstn_i         (Rstn_i),
    .cmd_i          (cmd_head),
    .cmd_empty_i    (cmd_empty),
    .cmd_pop_o      (cmd_pop),
    .data_i         (data_head),
    .data_pop_o     (data_pop),
    .requester_id_i (requester_id_i),
    .tx_st_o        (tx_st_o),
    .TxStReady_i    (TxStReady_i)
  );

endmodule

//--- avtx_tlp_fsm.sv
/*
  Memory write TLP transmitter.
  Sends a 3-DW header beat for the command at the FIFO head, then one
  payload beat per burst word from the data FIFO. Beats hold stable
  while the link is not ready, and back-to-back commands go out
  without an idle cycle between them.
*/
`timescale 1ns/100ps

module avtx_tlp_fsm (
  input  logic                          Clk_i,
  input  logic                          Rstn_i,
  input  avtx_pkg::tlp_cmd_t            cmd_i,
  input  logic                          cmd_empty_i,
  output logic                          cmd_pop_o,
  input  logic [avtx_pkg::DATA_W-1:0]   data_i,
  output logic                          data_pop_o,
  input  logic [15:0]                   requester_id_i,
  output avtx_pkg::tx_st_t              tx_st_o,
  input  logic                          TxStReady_i
);

  typedef enum logic [1:0] {
    IDLE,
    HDR,
    DATA
  } state_e;

  state_e                        state_q;
  state_e                        state_d;
  avtx_pkg::tlp_beat_u           beat;
  logic                          cnt_load;
  logic                          cnt_last;
  logic [avtx_pkg::BURST_W-1:0]  beat_cnt;

  // Payload beats in this TLP
  assign beat_cnt = cmd_i.len[avtx_pkg::BURST_W+1:2];

  avtx_beat_counter i_beat_counter (
    .Clk_i   (Clk_i),
    .Rstn_i  (Rstn_i),
    .load_i  (cnt_load),
    .count_i (beat_cnt),
    .step_i  (data_pop_o),
    .last_o  (cnt_last),
    .busy_o  ()
  );

  always_comb
  begin
    state_d    = state_q;
    beat       = '0;
    cnt_load   = 1'b0;
    cmd_pop_o  = 1'b0;
    data_pop_o = 1'b0;
    tx_st_o.valid = 1'b0;
    tx_st_o.sop   = 1'b0;
    tx_st_o.eop   = 1'b0;
    case (state_q)
      IDLE:
      begin
        if (!cmd_empty_i)
          state_d = HDR;
      end
      HDR:
      begin
        tx_st_o.valid = 1'b1;
        tx_st_o.sop   = 1'b1;
        beat.hdr.dw3      = '0;
        beat.hdr.dw2      = {cmd_i.addr[31:2], 2'b00};
        beat.hdr.req_id   = requester_id_i;
        beat.hdr.last_be  = 4'hF;                // Whole dwords only
        beat.hdr.first_be = 4'hF;
        beat.hdr.fmt_type = avtx_pkg::TLP_FMT_MWR32;
        beat.hdr.length   = cmd_i.len;
        if (TxStReady_i)
        begin
          cmd_pop_o = 1'b1;
          cnt_load  = 1'b1;
          state_d   = DATA;
        end
      end
      DATA:
      begin
        tx_st_o.valid = 1'b1;
        tx_st_o.eop   = cnt_last;
        beat.data     = data_i;
        if (TxStReady_i)
        begin
          data_pop_o = 1'b1;
          if (cnt_last)
            state_d = cmd_empty_i ? IDLE : HDR;  // Next TLP straight away
        end
      end
      default: state_d = IDLE;
    endcase
    tx_st_o.data = beat;
  end

  always_ff @(posedge Clk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
      state_q <= IDLE;
    else
      state_q <= state_d;
  end

endmodule

//--- avtx_avl_slave.sv
/*
  Avalon-MM burst write slave.
  Asserts wait-request only between bursts, while the queues cannot
  take a full burst. Each accepted word goes to the data FIFO; the
  first beat's translated address and the burst length form a command
  that is pushed on the cycle after the last beat.
*/
`timescale 1ns/100ps

module avtx_avl_slave #(
  parameter int AVL_ADDR_W = 14,
  parameter int CMD_DEPTH  = 8,
  parameter int DATA_DEPTH = 64,
  parameter int MAX_BURST  = 16
) (
  input  logic                              Clk_i,
  input  logic                              Rstn_i,
  input  avtx_pkg::avl_wr_t                 avl_wr_i,
  output logic                              TxWaitRequest_o,
  output logic [AVL_ADDR_W+3:0]             lookup_addr_o,
  input  logic [31:0]                       pcie_addr_i,
  output logic                              data_push_o,
  output logic [avtx_pkg::DATA_W-1:0]       data_o,
  output logic                              cmd_push_o,
  output avtx_pkg::tlp_cmd_t                cmd_o,
  input  logic [$clog2(CMD_DEPTH):0]        cmd_free_i,
  input  logic [$clog2(DATA_DEPTH):0]       data_free_i
);

  localparam int LEN_PAD = 10 - avtx_pkg::BURST_W - 2;

  avtx_pkg::tlp_cmd_t cmd_q;
  logic               cmd_push_q;
  logic               accept;
  logic               first_beat;
  logic               in_burst;
  logic               last_beat;

  // A command still on its way to the FIFO is counted as used
  assign TxWaitRequest_o = ~in_burst &
                           ((cmd_free_i <= cmd_push_q) || (data_free_i < MAX_BURST));

  assign accept     = avl_wr_i.write & ~TxWaitRequest_o;
  assign first_beat = accept & ~in_burst;

  assign lookup_addr_o = {avl_wr_i.address[AVL_ADDR_W-1:0], 4'h0};
  assign data_push_o   = accept;
  assign data_o        = avl_wr_i.writedata;

  avtx_beat_counter i_beat_counter (
    .Clk_i   (Clk_i),
    .Rstn_i  (Rstn_i),
    .load_i  (first_beat),
    .count_i (avl_wr_i.burstcount),
    .step_i  (accept),
    .last_o  (last_beat),
    .busy_o  (in_burst)
  );

  always_ff @(posedge Clk_i)
  begin
    if (first_beat)
    begin
      cmd_q.addr <= pcie_addr_i;
      cmd_q.len  <= {{LEN_PAD{1'b0}}, avl_wr_i.burstcount, 2'b00};  // 4 dwords per word
    end
  end

  always_ff @(posedge Clk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
      cmd_push_q <= 1'b0;
    else
      cmd_push_q <= accept & last_beat;
  end

  assign cmd_push_o = cmd_push_q;
  assign cmd_o      = cmd_q;

endmodule

//--- avtx_addr_table.sv
/*
  Avalon to PCIe address translation table.
  Entries are programmed over APB, one dword register per entry, and
  only the bits above the pass-through field are kept. The top bits of
  the Avalon byte address pick an entry; the low bits pass unchanged.
*/
`timescale 1ns/100ps

module avtx_addr_table #(
  parameter int AVL_ADDR_W = 14,
  parameter int PASS_BITS  = 16
) (
  input  logic                     Clk_i,
  input  logic                     Rstn_i,
  input  avtx_pkg::apb_req_t       apb_req_i,
  output avtx_pkg::apb_rsp_t       apb_rsp_o,
  input  logic [AVL_ADDR_W+3:0]    lookup_addr_i,   // Byte address
  output logic [31:0]              pcie_addr_o
);

  localparam int BYTE_W    = AVL_ADDR_W + 4;
  localparam int IDX_W     = BYTE_W - PASS_BITS;
  localparam int N_ENTRIES = 1 << IDX_W;
  localparam int ENTRY_W   = 32 - PASS_BITS;

  logic [ENTRY_W-1:0] entry_q [N_ENTRIES];
  logic [5:0]         reg_idx;
  logic               access;
  logic               in_range;

  assign reg_idx  = apb_req_i.paddr[7:2];            // One dword per entry
  assign access   = apb_req_i.psel & apb_req_i.penable;
  assign in_range = (reg_idx < N_ENTRIES);

  always_ff @(posedge Clk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
    begin
      for (int i = 0; i < N_ENTRIES; i++)
      begin
        entry_q[i] <= '0;
      end
    end
    else if (access && apb_req_i.pwrite && in_range)
    begin
      entry_q[reg_idx[IDX_W-1:0]] <= apb_req_i.pwdata[31:PASS_BITS];
    end
  end

  // Access phase always completes in one cycle
  always_comb
  begin
    apb_rsp_o.pready  = 1'b1;
    apb_rsp_o.pslverr = access & ~in_range;
    if (in_range)
    begin
      apb_rsp_o.prdata = {entry_q[reg_idx[IDX_W-1:0]], {PASS_BITS{1'b0}}};
    end
    else
    begin
      apb_rsp_o.prdata = '0;
    end
  end

  // Page base from the table, offset within the page from Avalon
  assign pcie_addr_o = {entry_q[lookup_addr_i[BYTE_W-1:PASS_BITS]],
                        lookup_addr_i[PASS_BITS-1:0]};

endmodule

//--- avtx_fifo.sv
/*
  Synchronous first-word-fall-through FIFO.
  Register-array ring buffer whose head word is always on dout_o when
  not empty. Reports the number of free words for flow control.
*/
`timescale 1ns/100ps

module avtx_fifo #(
  parameter int WIDTH = 42,
  parameter int DEPTH = 8
) (
  input  logic                     Clk_i,
  input  logic                     Rstn_i,
  input  logic                     push_i,
  input  logic [WIDTH-1:0]         din_i,
  input  logic                     pop_i,
  output logic [WIDTH-1:0]         dout_o,
  output logic                     empty_o,
  output logic [$clog2(DEPTH):0]   free_o
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = PTR_W + 1;

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;

  always_ff @(posedge Clk_i)
  begin
    if (push_i)
    begin
      mem[wr_ptr_q] <= din_i;
    end
  end

  always_ff @(posedge Clk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      if (push_i)
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH-1)) ? '0 : wr_ptr_q + 1'b1;
      if (pop_i)
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH-1)) ? '0 : rd_ptr_q + 1'b1;
      count_q <= count_q + CNT_W'(push_i) - CNT_W'(pop_i);
    end
  end

  assign dout_o  = mem[rd_ptr_q];               // Head word
  assign empty_o = (count_q == '0);
  assign free_o  = CNT_W'(DEPTH) - count_q;

endmodule

//--- avtx_beat_counter.sv
/*
  Burst beat counter.
  Loads a beat count and counts down on every moved beat. A load on the
  same cycle as a step counts that beat, so the first beat of a burst
  is covered by the same last-beat flag as the rest.
*/
`timescale 1ns/100ps

module avtx_beat_counter (
  input  logic                          Clk_i,
  input  logic                          Rstn_i,
  input  logic                          load_i,
  input  logic [avtx_pkg::BURST_W-1:0]  count_i,
  input  logic                          step_i,
  output logic                          last_o,
  output logic                          busy_o
);

  logic [avtx_pkg::BURST_W-1:0] rem_q;      // Beats still to move
  logic [avtx_pkg::BURST_W-1:0] rem_cur;

  assign rem_cur = load_i ? count_i : rem_q;

  always_ff @(posedge Clk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
      rem_q <= '0;
    else if (load_i || step_i)
      rem_q <= rem_cur - avtx_pkg::BURST_W'(step_i);
  end

  assign last_o = (rem_cur == avtx_pkg::BURST_W'(1));
  assign busy_o = (rem_q != '0);

endmodule

//--- avtx_pkg.sv
/*
  Shared definitions for the Avalon to PCIe memory write bridge.
  Holds the data path widths, the TLP encodings, the header layout,
  the stream beat union and the bus request and response structs.
*/
package avtx_pkg;

  localparam int DATA_W      = 128;
  localparam int BURST_W     = 5;           // Bursts of 1 to 16 words
  localparam int DW_PER_BEAT = 4;
  localparam int AVL_ADDR_MAX = 18;         // Widest Avalon word address carried

  localparam logic [7:0] TLP_FMT_MWR32 = 8'h40;  // 3-DW header, with data

  // One queued write, already translated
  typedef struct packed {
    logic [31:0] addr;                      // PCIe byte address
    logic [9:0]  len;                       // Length in dwords
  } tlp_cmd_t;

  // Header beat, most significant dword first
  typedef struct packed {
    logic [31:0] dw3;                       // Unused in a 3-DW header
    logic [31:0] dw2;                       // Address, dword aligned
    logic [15:0] req_id;
    logic [7:0]  tag;
    logic [3:0]  last_be;
    logic [3:0]  first_be;
    logic [7:0]  fmt_type;
    logic [13:0] rsvd;
    logic [9:0]  length;
  } tlp_hdr_t;

  // The same 128-bit word is either a header or payload
  typedef union packed {
    tlp_hdr_t            hdr;
    logic [DATA_W-1:0]   data;
  } tlp_beat_u;

  typedef struct packed {
    logic                    write;
    logic [AVL_ADDR_MAX-1:0] address;       // Word address, low bits used
    logic [BURST_W-1:0]      burstcount;
    logic [DATA_W-1:0]       writedata;
  } avl_wr_t;

  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

  typedef struct packed {
    logic      valid;
    logic      sop;
    logic      eop;
    tlp_beat_u data;
  } tx_st_t;

endpackage
